// File: run_sim.sh
#!/usr/bin/env bash
# build and run the port block testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f zx_ports.f --top-module zx_ports_tb -o zx_ports_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/zx_ports_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"
exit 0

// File: source/zx_bus_strobe.sv
/*
 bus levels must be stable at the zpos sampling edge
 one strobe per io write cycle, a and din held until the register loads
*/
`timescale 1ns/100ps
`include "zx_ports_settings.svh"

module zx_bus_strobe import zx_ports_pkg::*;
(
	input  logic     fclk,
	input  logic     rst_n,
	input  logic     zpos,
	input  zaddr_t   a,
	input  logic     iorq_n,
	input  logic     wr_n,
	input  logic     shadow,
	output port_wr_t port_wr
);

	logic     iowr_s; // io write seen at zpos
	logic     iowr_d; // previous sample
	logic     wr_evt;
	logic [7:0] loa;
	port_wr_t dec;

	assign loa = a[7:0];

	//////////////////////////////////////////////////
	// write edge detect
	//////////////////////////////////////////////////
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_s <= 1'b0;
			iowr_d <= 1'b0;
		end
		else
		begin
			if (zpos)
				iowr_s <= ~(iorq_n | wr_n);
			iowr_d <= iowr_s; // every fclk
		end
	end

	assign wr_evt = iowr_s & ~iowr_d; // high for one fclk only

	// port select from low byte
	always_comb
	begin
		dec.fe      = (loa == `ZXP_PORT_FE) || (loa == `ZXP_PORT_F6) || (loa == `ZXP_PORT_FC);
		dec.p7ffd   = ((loa == `ZXP_PORT_FD) || (loa == `ZXP_PORT_FC)) && !a[15];
		dec.peff7   = (loa == `ZXP_PORT_F7) && a[8] && !a[12] && !shadow; // EFF7 gone in shadow
		dec.bf      = (loa == `ZXP_PORT_BF);
		dec.be      = (loa == `ZXP_PORT_BE);
		dec.bd      = (loa == `ZXP_PORT_BD);
		dec.up_reg  = (loa == `ZXP_PORT_3B) && !a[14];
		dec.up_data = (loa == `ZXP_PORT_3B) && a[14];
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			port_wr <= '0;
		else
			port_wr <= wr_evt ? dec : '0;
	end

	// FC hits FE and 7FFD together by design, so that pair counts as one
	a_strobe_onehot: assert property (@(posedge fclk) disable iff (!rst_n)
		$onehot0({port_wr.fe | port_wr.p7ffd, port_wr.peff7, port_wr.bf, port_wr.be,
			port_wr.bd, port_wr.up_reg, port_wr.up_data}));

endmodule

// File: source/zx_paging_regs.sv
/*
 7FFD is frozen while 7FFD.5 and EFF7.2 are both set
 raw bytes go to BD read-back, masked bytes go to the memory pager
*/
`timescale 1ns/100ps
`include "zx_ports_settings.svh"

module zx_paging_regs import zx_ports_pkg::*;
(
	input  logic     fclk,
	input  logic     rst_n,
	input  zdata_t   din,
	input  port_wr_t port_wr,
	output paging_t  paging,
	output zdata_t   p7ffd,
	output zdata_t   peff7,
	output page_t    pent1m_page,
	output logic     pent1m_rom,
	output logic     pent1m_1m_on,
	output logic     pent1m_ram0_0
);

	zdata_t p7ffd_raw; // 2..0 page, 3 screen, 4 rom, 5 lock48, 7..6 1M page
	zdata_t peff7_raw; // 0 16c, 2 no 1M, 3 ram at 0000
	logic   block1m;
	logic   lock;

	assign block1m = peff7_raw[2];
	assign lock    = p7ffd_raw[5] & block1m; // 48K lock only in 128K mode

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_raw <= `ZXP_RST_P7FFD;
		else if (port_wr.p7ffd && !lock)
			p7ffd_raw <= din;
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			peff7_raw <= `ZXP_RST_PEFF7;
		else if (port_wr.peff7) // shadow already decoded
			peff7_raw <= din;
	end

	//////////////////////////////////////////////////
	// pager view
	//////////////////////////////////////////////////
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_raw[7:5]), p7ffd_raw[4:0]};
	assign peff7 = block1m ?
		{peff7_raw[7], 1'b0, peff7_raw[5], peff7_raw[4], 3'b000, peff7_raw[0]} : peff7_raw;

	assign pent1m_page   = {p7ffd_raw[7:5], p7ffd_raw[2:0]};
	assign pent1m_rom    = p7ffd_raw[4];
	assign pent1m_1m_on  = ~block1m;
	assign pent1m_ram0_0 = peff7_raw[3];

	assign paging.p7ffd = p7ffd_raw; // unmasked for read-back
	assign paging.peff7 = peff7_raw;

	// lock must hold against any 7FFD strobe
	a_lock_holds: assert property (@(posedge fclk) disable iff (!rst_n)
		lock |=> $stable(p7ffd_raw));

endmodule

// File: source/zx_port_readback.sv
/*
 purely combinational, dout valid as soon as a settles
 F7 and 1F vanish from the port map in shadow mode
*/
`timescale 1ns/100ps
`include "zx_ports_settings.svh"

module zx_port_readback import zx_ports_pkg::*;
(
	input  zaddr_t     a,
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic       shadow,
	input  logic [4:0] keys_in,
	input  logic [4:0] kj_in,
	input  logic       tape_read,
	input  paging_t    paging,
	input  sys_cfg_t   cfg,
	output zdata_t     dout,
	output logic       porthit,
	output logic       dataout
);

	logic [7:0] loa;
	bd_sel_t    bd_sel;
	zdata_t     bd_mux;

	assign loa    = a[7:0];
	assign bd_sel = a[12:8];

	always_comb
	begin
		porthit = (loa == `ZXP_PORT_FE) || (loa == `ZXP_PORT_F6) ||
			(loa == `ZXP_PORT_FC) || (loa == `ZXP_PORT_FD) ||
			(loa == `ZXP_PORT_BF) || (loa == `ZXP_PORT_BE) ||
			(loa == `ZXP_PORT_BD) || (loa == `ZXP_PORT_3B) ||
			(((loa == `ZXP_PORT_F7) || (loa == `ZXP_PORT_1F)) && !shadow);
	end

	assign dataout = porthit & ~iorq_n & ~rd_n; // drive z80 data bus

	//////////////////////////////////////////////////
	// BD/BE sub-address mux
	//////////////////////////////////////////////////
	always_comb
	begin
		case (bd_sel)
			`ZXP_BD_P7FFD:   bd_mux = paging.p7ffd;
			`ZXP_BD_PEFF7:   bd_mux = paging.peff7;
			`ZXP_BD_BORDER:  bd_mux = {4'h0, cfg.border};
			`ZXP_BD_LOBRK:   bd_mux = cfg.brk_addr[7:0];
			`ZXP_BD_HIBRK:   bd_mux = cfg.brk_addr[15:8];
			`ZXP_BD_FDDMASK: bd_mux = {4'h0, cfg.fdd_mask};
			default:         bd_mux = `ZXP_IDLE_READ;
		endcase
	end

	always_comb
	begin
		case (loa)
			`ZXP_PORT_FE, `ZXP_PORT_F6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			`ZXP_PORT_1F:
				dout = shadow ? `ZXP_IDLE_READ : {3'b000, kj_in}; // kempston
			`ZXP_PORT_BF:
				dout = {3'b000, cfg.brk_ena, cfg.set_nmi, cfg.fntw_en,
					cfg.romrw_en, cfg.shadow_en};
			`ZXP_PORT_BD, `ZXP_PORT_BE:
				dout = bd_mux;
			`ZXP_PORT_3B:
				dout = cfg.up_last;
			default:
				dout = `ZXP_IDLE_READ; // incl. F7 and FC reads
		endcase
	end

endmodule

// File: source/zx_ports.sv
/*
 fclk-domain port block, bus levels sampled on zpos
 shadow is dos or BF bit0
*/
`timescale 1ns/100ps

module zx_ports import zx_ports_pkg::*;
(
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       zpos,
	input  zaddr_t     a,
	input  zdata_t     din,
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic       wr_n,
	input  logic       dos,
	input  logic [4:0] keys_in,
	input  logic [4:0] kj_in,
	input  logic       tape_read,
	output zdata_t     dout,
	output logic       porthit,
	output logic       dataout,
	output logic       shadow,
	output zdata_t     p7ffd,
	output zdata_t     peff7,
	output page_t      pent1m_page,
	output logic       pent1m_rom,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0,
	output border_t    border,
	output logic       romrw_en,
	output logic       fntw_en,
	output logic       set_nmi,
	output logic       brk_ena,
	output zaddr_t     brk_addr,
	output logic [3:0] fdd_mask,
	output logic       beeper_wr,
	output logic       clr_nmi,
	output logic       up_ena,
	output pal_addr_t  up_paladdr,
	output zdata_t     up_paldata,
	output logic       up_palwr
);

	port_wr_t port_wr;
	paging_t  paging;
	sys_cfg_t cfg;

	zx_bus_strobe i_strobe (.fclk, .rst_n, .zpos, .a, .iorq_n, .wr_n, .shadow, .port_wr);

	zx_paging_regs i_paging (.fclk, .rst_n, .din, .port_wr, .paging, .p7ffd, .peff7,
		.pent1m_page, .pent1m_rom, .pent1m_1m_on, .pent1m_ram0_0);

	zx_system_regs i_sys (.fclk, .rst_n, .a, .din, .dos, .port_wr, .cfg, .shadow, .border,
		.romrw_en, .fntw_en, .set_nmi, .brk_ena, .brk_addr, .fdd_mask, .beeper_wr,
		.clr_nmi, .up_ena, .up_paladdr, .up_paldata, .up_palwr);

	zx_port_readback i_rdback (.a, .iorq_n, .rd_n, .shadow, .keys_in, .kj_in, .tape_read,
		.paging, .cfg, .dout, .porthit, .dataout);

endmodule

// File: source/zx_ports_pkg.sv
/*
 shared types of the port block
 struct field order is the bit order seen by the testbench
*/
package zx_ports_pkg;

	typedef logic [15:0] zaddr_t;    // z80 address
	typedef logic [7:0]  zdata_t;    // z80 data byte
	typedef logic [4:0]  bd_sel_t;   // a[12:8] of BD/BE
	typedef logic [5:0]  page_t;     // 1M page number
	typedef logic [3:0]  border_t;   // border colour
	typedef logic [5:0]  pal_addr_t; // ulaplus palette index

	// one-cycle write strobes
	typedef struct packed {
		logic fe;
		logic p7ffd;
		logic peff7;
		logic bf;
		logic be;
		logic bd;
		logic up_reg;  // 0xBF3B
		logic up_data; // 0xFF3B
	} port_wr_t;

	// raw paging bytes, unmasked
	typedef struct packed {
		zdata_t p7ffd;
		zdata_t peff7;
	} paging_t;

	typedef struct packed {
		logic    shadow_en;
		logic    romrw_en;
		logic    fntw_en;
		logic    set_nmi;
		logic    brk_ena;
		border_t border;
		zaddr_t  brk_addr;
		logic [3:0] fdd_mask;
		zdata_t  up_last; // last ulaplus data write
	} sys_cfg_t;

	typedef enum logic {
		UP_GROUP_PALETTE = 1'b0,
		UP_GROUP_MODE    = 1'b1
	} up_group_e;

endpackage

// File: source/zx_ports_settings.svh
/*
 port numbers are the low address byte only, upper bits decoded per port
 BD sub-addresses come from a[12:8]
*/
`ifndef ZX_PORTS_SETTINGS_SVH
`define ZX_PORTS_SETTINGS_SVH

//////////////////////////////////////////////////
// port low bytes
//////////////////////////////////////////////////
`define ZXP_PORT_FE 8'hFE // border, beeper, keys
`define ZXP_PORT_F6 8'hF6 // FE alias
`define ZXP_PORT_FC 8'hFC // aliases both FE and 7FFD
`define ZXP_PORT_FD 8'hFD // 7FFD
`define ZXP_PORT_F7 8'hF7 // EFF7
`define ZXP_PORT_BF 8'hBF // config
`define ZXP_PORT_BE 8'hBE // nmi end, config read
`define ZXP_PORT_BD 8'hBD // config read and write
`define ZXP_PORT_3B 8'h3B // ulaplus
`define ZXP_PORT_1F 8'h1F // kempston

// BD/BE sub-addresses
`define ZXP_BD_P7FFD   5'h0A
`define ZXP_BD_PEFF7   5'h0B
`define ZXP_BD_BORDER  5'h0F
`define ZXP_BD_LOBRK   5'h10
`define ZXP_BD_HIBRK   5'h11
`define ZXP_BD_FDDMASK 5'h13

// reset values
`define ZXP_RST_P7FFD   8'h00
`define ZXP_RST_PEFF7   8'h00
`define ZXP_RST_BORDER  4'h0
`define ZXP_RST_BRKADDR 16'h0000
`define ZXP_RST_FDDMASK 4'h0

`define ZXP_IDLE_READ 8'hFF // floating bus

`endif

// File: source/zx_system_regs.sv
/*
 a and din must still be valid in the strobe cycle
 ulaplus palette data is passed straight from din with the strobe
*/
`timescale 1ns/100ps
`include "zx_ports_settings.svh"

module zx_system_regs import zx_ports_pkg::*;
(
	input  logic       fclk,
	input  logic       rst_n,
	input  zaddr_t     a,
	input  zdata_t     din,
	input  logic       dos,
	input  port_wr_t   port_wr,
	output sys_cfg_t   cfg,
	output logic       shadow,
	output border_t    border,
	output logic       romrw_en,
	output logic       fntw_en,
	output logic       set_nmi,
	output logic       brk_ena,
	output zaddr_t     brk_addr,
	output logic [3:0] fdd_mask,
	output logic       beeper_wr,
	output logic       clr_nmi,
	output logic       up_ena,
	output pal_addr_t  up_paladdr,
	output zdata_t     up_paldata,
	output logic       up_palwr
);

	logic      shadow_en;
	bd_sel_t   bd_sel;
	up_group_e up_group;
	zdata_t    up_last;

	assign bd_sel = a[12:8];
	assign shadow = dos | shadow_en;

	//////////////////////////////////////////////////
	// BF, FE, BD writes
	//////////////////////////////////////////////////
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			{brk_ena, set_nmi, fntw_en, romrw_en, shadow_en} <= 5'b00000;
			border   <= `ZXP_RST_BORDER;
			brk_addr <= `ZXP_RST_BRKADDR;
			fdd_mask <= `ZXP_RST_FDDMASK;
		end
		else
		begin
			if (port_wr.bf)
				{brk_ena, set_nmi, fntw_en, romrw_en, shadow_en} <= din[4:0];
			if (port_wr.fe)
				border <= {~a[3], din[2:0]}; // bright from a3
			if (port_wr.bd && (bd_sel == `ZXP_BD_LOBRK || bd_sel == `ZXP_BD_HIBRK))
			begin
				if (a[8])
					brk_addr[15:8] <= din;
				else
					brk_addr[7:0] <= din;
			end
			if (port_wr.bd && bd_sel == `ZXP_BD_FDDMASK)
				fdd_mask <= din[3:0];
		end
	end

	//////////////////////////////////////////////////
	// ulaplus
	//////////////////////////////////////////////////
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			up_group <= UP_GROUP_PALETTE;
			up_ena   <= 1'b0;
		end
		else
		begin
			if (port_wr.up_reg && din[7:6] == 2'b01)
				up_group <= UP_GROUP_MODE;
			else if (port_wr.up_reg && din[7:6] == 2'b00)
				up_group <= UP_GROUP_PALETTE;
			if (port_wr.up_data && up_group == UP_GROUP_MODE)
				up_ena <= din[0];
		end
	end

	always_ff @(posedge fclk)
	begin
		if (port_wr.up_reg && din[7:6] == 2'b00)
			up_paladdr <= din[5:0];
		if (port_wr.up_data)
			up_last <= din; // read back on 3B
	end

	assign up_palwr   = port_wr.up_data && (up_group == UP_GROUP_PALETTE);
	assign up_paldata = {din[4:2], din[7:5], din[1:0]}; // G3R3B2 -> R3G3B2

	assign beeper_wr = port_wr.fe && (a[7:0] == `ZXP_PORT_FE); // not on the aliases
	assign clr_nmi   = port_wr.be;

	assign cfg = '{shadow_en: shadow_en, romrw_en: romrw_en, fntw_en: fntw_en,
		set_nmi: set_nmi, brk_ena: brk_ena, border: border, brk_addr: brk_addr,
		fdd_mask: fdd_mask, up_last: up_last};

	// border only moves on an FE strobe from the bus front end
	a_border_on_fe: assert property (@(posedge fclk) disable iff (!rst_n)
		!port_wr.fe |=> $stable(border));

endmodule

// File: verification/zx_ports_clkgen.sv
/*
 fclk of 20 ns, zpos high on every second fclk cycle
 rst_n held low for the first 2 rising edges
*/
`timescale 1ns/100ps

module zx_ports_clkgen
(
	output logic fclk,
	output logic zpos,
	output logic rst_n
);

	initial
	begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk; // 20 ns period
	end

	initial
		zpos = 1'b0;

	always @(posedge fclk)
		zpos <= ~zpos; // high every second edge

	initial
	begin
		rst_n = 1'b0;
		repeat (2) @(posedge fclk);
		#2 rst_n = 1'b1; // release off the edge
	end

endmodule

// File: verification/zx_ports_tb.sv
/*
 directed tests run in order and share register state
 inputs change 2 ns after posedge, outputs sampled at negedge
*/
`timescale 1ns/100ps
`include "zx_ports_settings.svh"

module zx_ports_tb import zx_ports_pkg::*;
();

	logic       fclk, zpos, rst_n;
	zaddr_t     a;
	zdata_t     din;
	logic       iorq_n, rd_n, wr_n, dos, tape_read;
	logic [4:0] keys_in, kj_in;
	zdata_t     dout, p7ffd, peff7, up_paldata;
	logic       porthit, dataout, shadow, pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	page_t      pent1m_page;
	border_t    border;
	logic       romrw_en, fntw_en, set_nmi, brk_ena, beeper_wr, clr_nmi, up_ena, up_palwr;
	zaddr_t     brk_addr;
	logic [3:0] fdd_mask;
	pal_addr_t  up_paladdr;

	int     errors, checks, test_errs, tests;
	int     beeper_cnt, clrnmi_cnt, palwr_cnt;
	zdata_t paldata_seen;

	zx_ports_clkgen i_clkgen (.fclk, .zpos, .rst_n);

	zx_ports i_zx_ports (.*);

	// pulse monitor, mid-cycle
	initial
	begin
		beeper_cnt = 0;
		clrnmi_cnt = 0;
		palwr_cnt  = 0;
	end

	always @(negedge fclk)
	begin
		if (beeper_wr)
			beeper_cnt++;
		if (clr_nmi)
			clrnmi_cnt++;
		if (up_palwr)
		begin
			palwr_cnt++;
			paldata_seen = up_paldata; // din still held here
		end
	end

	//////////////////////////////////////////////////
	// check and report helpers
	//////////////////////////////////////////////////
	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("error %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		errors++;
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == test_errs)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - test_errs);
		test_errs = errors;
	endtask

	function automatic zaddr_t bd_addr(input bd_sel_t sel, input logic [7:0] port);
		return {3'b000, sel, port};
	endfunction

	//////////////////////////////////////////////////
	// bus cycles
	//////////////////////////////////////////////////
	// ends 2 ns after a zpos sampling edge
	task automatic wait_zpos;
		int n;
		n = 0;
		@(negedge fclk);
		while (!zpos && n < 8)
		begin
			@(negedge fclk);
			n++;
		end
		if (!zpos)
			report_failure("timeout while waiting for zpos to go high");
		@(posedge fclk);
		#2;
	endtask

	task automatic io_write(input zaddr_t addr, input zdata_t data);
		@(posedge fclk);
		#2;
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (4) wait_zpos; // held over 4 samples
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		repeat (2) wait_zpos; // seen idle before next cycle
	endtask

	// hit is the expected port decode for addr
	task automatic io_read(input zaddr_t addr, input logic hit, output zdata_t data);
		@(posedge fclk);
		#2;
		a      = addr;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		@(negedge fclk);
		data = dout;
		check_val("porthit", porthit, hit);
		check_val("dataout", dataout, hit);
		@(posedge fclk);
		#2;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		@(negedge fclk);
		check_val("dataout", dataout, 1'b0); // bus released
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	task automatic test_reset;
		zdata_t d;
		check_val("p7ffd", p7ffd, 8'h00);
		check_val("peff7", peff7, 8'h00);
		check_val("border", border, 4'h0);
		check_val("up_ena", up_ena, 1'b0);
		check_val("brk_addr", brk_addr, 16'h0000);
		check_val("shadow", shadow, 1'b0);
		check_val("pent1m_1m_on", pent1m_1m_on, 1'b1); // 1M on while EFF7.2 clear
		check_val("pent1m_ram0_0", pent1m_ram0_0, 1'b0);
		io_read(16'h00BF, 1'b1, d);
		check_val("dout", d, 8'h00);
		finish_test("reset state");
	endtask

	task automatic test_border;
		zdata_t d;
		int     beeps;
		beeps = beeper_cnt;
		io_write(16'h00FE, 8'h05); // a3 set
		check_val("border", border, 4'h5);
		check_val("beeper_wr pulses", beeper_cnt - beeps, 1);
		@(posedge fclk);
		#2;
		keys_in   = 5'($urandom);
		tape_read = 1'($urandom);
		io_read(16'h7FFE, 1'b1, d);
		check_val("dout", d, {1'b1, tape_read, 1'b0, keys_in});
		finish_test("border and input port");
	endtask

	task automatic test_paging;
		zdata_t d;
		io_write(16'h7FFD, 8'h27);
		check_val("p7ffd", p7ffd, 8'h27);
		check_val("pent1m_page", pent1m_page, 6'h0F);
		check_val("pent1m_rom", pent1m_rom, 1'b0);
		io_write(16'hEFF7, 8'h04); // 128K mode, lock armed
		check_val("p7ffd", p7ffd, 8'h07);
		check_val("peff7", peff7, 8'h00);
		check_val("pent1m_1m_on", pent1m_1m_on, 1'b0);
		io_write(16'h7FFD, 8'h10);
		io_read(bd_addr(`ZXP_BD_P7FFD, `ZXP_PORT_BD), 1'b1, d);
		check_val("dout", d, 8'h27);
		io_read(bd_addr(`ZXP_BD_PEFF7, `ZXP_PORT_BD), 1'b1, d);
		check_val("dout", d, 8'h04);
		finish_test("paging and lock");
	endtask

	task automatic test_shadow;
		zdata_t d;
		int     nmis;
		@(posedge fclk);
		#2;
		kj_in = 5'($urandom);
		io_read(16'h001F, 1'b1, d); // kempston visible
		check_val("dout", d, {3'b000, kj_in});
		io_write(16'h00BF, 8'h01);
		check_val("shadow", shadow, 1'b1);
		io_read(16'h00BF, 1'b1, d);
		check_val("dout", d, 8'h01);
		io_read(16'h001F, 1'b0, d);
		check_val("dout", d, `ZXP_IDLE_READ);
		io_write(16'hEFF7, 8'h00);
		io_read(bd_addr(`ZXP_BD_PEFF7, `ZXP_PORT_BD), 1'b1, d);
		check_val("dout", d, 8'h04);
		// other config bits set, shadow_en cleared
		io_write(16'h00BF, 8'h1E);
		check_val("romrw_en", romrw_en, 1'b1);
		check_val("fntw_en", fntw_en, 1'b1);
		check_val("set_nmi", set_nmi, 1'b1);
		check_val("brk_ena", brk_ena, 1'b1);
		io_read(16'h00BF, 1'b1, d);
		check_val("dout", d, 8'h1E);
		// same again, shadow from dos
		@(posedge fclk);
		#2;
		dos = 1'b1;
		@(negedge fclk);
		check_val("shadow", shadow, 1'b1);
		io_read(16'h001F, 1'b0, d);
		check_val("dout", d, `ZXP_IDLE_READ);
		io_write(16'hEFF7, 8'h00);
		io_read(bd_addr(`ZXP_BD_PEFF7, `ZXP_PORT_BD), 1'b1, d);
		check_val("dout", d, 8'h04);
		@(posedge fclk);
		#2;
		dos = 1'b0;
		io_write(16'hEFF7, 8'h08); // visible again, ram at 0000
		check_val("pent1m_1m_on", pent1m_1m_on, 1'b1);
		check_val("pent1m_ram0_0", pent1m_ram0_0, 1'b1);
		io_write(16'h7FFD, 8'h10); // lock gone
		check_val("pent1m_rom", pent1m_rom, 1'b1);
		nmis = clrnmi_cnt;
		io_write(16'h00BE, 8'h00);
		check_val("clr_nmi pulses", clrnmi_cnt - nmis, 1);
		finish_test("shadow");
	endtask

	task automatic test_bd_regs;
		zdata_t d;
		io_write(bd_addr(`ZXP_BD_LOBRK, `ZXP_PORT_BD), 8'h34);
		io_write(bd_addr(`ZXP_BD_HIBRK, `ZXP_PORT_BD), 8'h12);
		io_write(bd_addr(`ZXP_BD_FDDMASK, `ZXP_PORT_BD), 8'hA5);
		check_val("brk_addr", brk_addr, 16'h1234);
		check_val("fdd_mask", fdd_mask, 4'h5);
		io_read(bd_addr(`ZXP_BD_LOBRK, `ZXP_PORT_BD), 1'b1, d);
		check_val("dout", d, 8'h34);
		io_read(bd_addr(`ZXP_BD_HIBRK, `ZXP_PORT_BE), 1'b1, d);
		check_val("dout", d, 8'h12);
		io_read(bd_addr(`ZXP_BD_FDDMASK, `ZXP_PORT_BD), 1'b1, d);
		check_val("dout", d, 8'h05);
		io_read(bd_addr(`ZXP_BD_BORDER, `ZXP_PORT_BE), 1'b1, d);
		check_val("dout", d, 8'h05); // border from the FE test
		finish_test("bd registers");
	endtask

	task automatic test_ulaplus;
		zdata_t d;
		int     pals;
		pals = palwr_cnt;
		io_write(16'hBF3B, 8'h05); // palette group, index 5
		io_write(16'hFF3B, 8'hE3);
		check_val("up_paladdr", up_paladdr, 6'h05);
		check_val("up_palwr pulses", palwr_cnt - pals, 1);
		check_val("up_paldata", paldata_seen, 8'h1F);
		pals = palwr_cnt;
		io_write(16'hBF3B, 8'h40); // mode group
		io_write(16'hFF3B, 8'h01);
		check_val("up_ena", up_ena, 1'b1);
		check_val("up_palwr pulses", palwr_cnt - pals, 0);
		io_read(16'hFF3B, 1'b1, d);
		check_val("dout", d, 8'h01);
		finish_test("ulaplus");
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial
	begin
		int unsigned seed;
		int n;
		seed      = $urandom(32'ha1f9);
		errors    = 0;
		checks    = 0;
		test_errs = 0;
		tests     = 0;
		a         = '0;
		din       = '0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		keys_in   = '0;
		kj_in     = '0;
		tape_read = 1'b0;
		n = 0;
		while (rst_n !== 1'b1 && n < 10)
		begin
			@(posedge fclk);
			n++;
		end
		if (rst_n !== 1'b1)
			report_failure("timeout while waiting for reset release");
		test_reset();
		test_border();
		test_paging();
		test_shadow();
		test_bd_regs();
		test_ulaplus();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: zx_ports.f
+incdir+source
source/zx_ports_pkg.sv
source/zx_bus_strobe.sv
source/zx_paging_regs.sv
source/zx_system_regs.sv
source/zx_port_readback.sv
source/zx_ports.sv
verification/zx_ports_clkgen.sv
verification/zx_ports_tb.sv
